// ==== fifo_pkg.sv ====
package fifo_pkg;

   // widest pointer the gray conversions handle
   localparam int PTR_MAX_W = 32;

   // per-domain port state
   // INIT holds both flags high for one clock after reset
   typedef enum logic [1:0] {
      INIT   = 2'd0,
      EMPTY  = 2'd1,
      NORMAL = 2'd2,
      FULL   = 2'd3
   } fifo_state_t;

   // narrower pointers are passed zero-extended and truncated by the caller
   function automatic logic [PTR_MAX_W-1:0] bin_to_gray(input logic [PTR_MAX_W-1:0] bin);
      return bin ^ (bin >> 1);
   endfunction

   // zero-extended upper bits stay zero through the xor chain
   function automatic logic [PTR_MAX_W-1:0] gray_to_bin(input logic [PTR_MAX_W-1:0] gray);
      logic [PTR_MAX_W-1:0] bin;
      bin[PTR_MAX_W-1] = gray[PTR_MAX_W-1];
      for (int i = PTR_MAX_W-2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

// ==== gray_counter.sv ====
`timescale 1ns/100ps

module gray_counter #(
   parameter int W = 4
) (
   input  logic         clk,
   input  logic         reset,
   input  logic         en,
   output logic [W-1:0] bin,
   output logic [W-1:0] gray
);

   import fifo_pkg::*;

   logic [W-1:0] bin_next;

   // wraps naturally at 2**W
   assign bin_next = bin + W'(1);

   // gray is registered so the crossing value comes straight from a flop
   always_ff @(posedge clk) begin
      if (reset) begin
         bin  <= '0;
         gray <= '0;
      end else if (en) begin
         bin  <= bin_next;
         gray <= W'(bin_to_gray(32'(bin_next)));
      end
   end

   // the synchronizer in the other domain relies on single-bit steps
   a_gray_one_bit: assert property (@(posedge clk) disable iff (reset)
      $countones(gray ^ $past(gray)) <= 1);

endmodule

// ==== gray_sync.sv ====
`timescale 1ns/100ps

module gray_sync #(
   parameter int W = 4
) (
   input  logic         clk,
   input  logic         reset,
   input  logic [W-1:0] gray_in,
   output logic [W-1:0] bin_out
);

   import fifo_pkg::*;

   // first stage may go metastable, second stage settles it
   logic [W-1:0] sync0;
   logic [W-1:0] sync1;

   always_ff @(posedge clk) begin
      if (reset) begin
         sync0 <= '0;
         sync1 <= '0;
      end else begin
         sync0 <= gray_in;
         sync1 <= sync0;
      end
   end

   // binary copy in the destination domain
   assign bin_out = W'(gray_to_bin(32'(sync1)));

endmodule

// ==== ram_t2p_asym.sv ====
`timescale 1ns/100ps

module ram_t2p_asym #(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   parameter int ADDR_W   = 6,
   localparam int MIN_W    = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W,
   localparam int W_RATIO  = W_DATA_W / MIN_W,
   localparam int R_RATIO  = R_DATA_W / MIN_W,
   localparam int W_SHIFT  = $clog2(W_RATIO),
   localparam int R_SHIFT  = $clog2(R_RATIO),
   localparam int W_ADDR_W = ADDR_W - W_SHIFT,
   localparam int R_ADDR_W = ADDR_W - R_SHIFT
) (
   // write port
   input  logic                w_clk,
   input  logic                w_en,
   input  logic [W_ADDR_W-1:0] w_addr,
   input  logic [W_DATA_W-1:0] w_data,

   // read port
   input  logic                r_clk,
   input  logic                r_en,
   input  logic [R_ADDR_W-1:0] r_addr,
   output logic [R_DATA_W-1:0] r_data
);

   localparam int MAX_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int RATIO = MAX_W / MIN_W;

   // storage in narrow words
   logic [MIN_W-1:0] mem [2**ADDR_W];

   // wide word spread over consecutive narrow locations, lsb part first
   always_ff @(posedge w_clk) begin
      if (w_en) begin
         for (int i = 0; i < W_RATIO; i++) begin
            mem[(ADDR_W'(w_addr) << W_SHIFT) + ADDR_W'(i)] <= w_data[i*MIN_W +: MIN_W];
         end
      end
   end

   // registered read, holds until the next enabled read
   always_ff @(posedge r_clk) begin
      if (r_en) begin
         for (int i = 0; i < R_RATIO; i++) begin
            r_data[i*MIN_W +: MIN_W] <= mem[(ADDR_W'(r_addr) << R_SHIFT) + ADDR_W'(i)];
         end
      end
   end

   // the address split above only works for power-of-two ratios
   a_width_ratio: assert property (@(posedge w_clk)
      (MAX_W % MIN_W == 0) && ((RATIO & (RATIO - 1)) == 0));

endmodule

// ==== fifo_async.sv ====
`timescale 1ns/100ps

module fifo_async #(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   // address width in narrow words
   parameter int ADDR_W   = 6
) (
   input  logic                reset,

   // write port
   input  logic                w_clk,
   input  logic                w_en,
   input  logic [W_DATA_W-1:0] w_data,
   output logic                w_empty,
   output logic                w_full,
   output logic [ADDR_W:0]     w_level,

   // read port
   input  logic                r_clk,
   input  logic                r_en,
   output logic [R_DATA_W-1:0] r_data,
   output logic                r_empty,
   output logic                r_full,
   output logic [ADDR_W:0]     r_level
);

   import fifo_pkg::*;

   localparam int MIN_W   = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int W_RATIO = W_DATA_W / MIN_W;
   localparam int R_RATIO = R_DATA_W / MIN_W;
   localparam int W_SHIFT = $clog2(W_RATIO);
   localparam int R_SHIFT = $clog2(R_RATIO);

   // the wider port counts in wide words, so its pointer is shorter
   localparam int W_PTR_W = ADDR_W - W_SHIFT;
   localparam int R_PTR_W = ADDR_W - R_SHIFT;

   // pointer steps and capacity in narrow words
   localparam logic [ADDR_W:0] W_INCR    = W_RATIO[ADDR_W:0];
   localparam logic [ADDR_W:0] R_INCR    = R_RATIO[ADDR_W:0];
   localparam logic [ADDR_W:0] FIFO_SIZE = {1'b1, {ADDR_W{1'b0}}};

   // write pointer in its own domain and synced to the read domain
   logic [W_PTR_W-1:0] w_wptr_bin;
   logic [W_PTR_W-1:0] w_wptr_gray;
   logic [W_PTR_W-1:0] r_wptr_bin;

   // read pointer in its own domain and synced to the write domain
   logic [R_PTR_W-1:0] r_rptr_bin;
   logic [R_PTR_W-1:0] r_rptr_gray;
   logic [R_PTR_W-1:0] w_rptr_bin;

   // pointers scaled to narrow words
   logic [ADDR_W-1:0] w_wptr_n;
   logic [ADDR_W-1:0] w_rptr_n;
   logic [ADDR_W-1:0] r_wptr_n;
   logic [ADDR_W-1:0] r_rptr_n;

   // raw differences wrap to 0 when full and the FSMs tell full from empty
   logic [ADDR_W-1:0] w_diff;
   logic [ADDR_W-1:0] r_diff;
   logic [ADDR_W:0]   w_fill;
   logic [ADDR_W:0]   r_fill;

   fifo_state_t w_st;
   fifo_state_t w_st_nxt;
   fifo_state_t r_st;
   fifo_state_t r_st_nxt;

   // strobes gated by the flags
   logic w_en_int;
   logic r_en_int;

   assign w_en_int = w_en & ~w_full;
   assign r_en_int = r_en & ~r_empty;

   assign w_wptr_n = ADDR_W'(w_wptr_bin) << W_SHIFT;
   assign w_rptr_n = ADDR_W'(w_rptr_bin) << R_SHIFT;
   assign r_wptr_n = ADDR_W'(r_wptr_bin) << W_SHIFT;
   assign r_rptr_n = ADDR_W'(r_rptr_bin) << R_SHIFT;

   assign w_diff = w_wptr_n - w_rptr_n;
   assign r_diff = r_wptr_n - r_rptr_n;

   // a zero difference means full only in the state that says so
   assign w_fill = (w_st == FULL && w_diff == '0) ? FIFO_SIZE : {1'b0, w_diff};
   assign r_fill = (r_st == NORMAL && r_diff == '0) ? FIFO_SIZE : {1'b0, r_diff};

   // write domain FSM
   always_ff @(posedge w_clk) begin
      if (reset) begin
         w_st <= INIT;
      end else begin
         w_st <= w_st_nxt;
      end
   end

   always_comb begin
      w_st_nxt = w_st;
      w_empty  = 1'b0;
      w_full   = 1'b0;
      w_level  = w_fill;
      case (w_st)
         INIT: begin
            w_empty  = 1'b1;
            w_full   = 1'b1;
            w_st_nxt = NORMAL;
         end
         FULL: begin
            w_full = 1'b1;
            // room for a whole write word again
            if (w_fill <= FIFO_SIZE - W_INCR) begin
               w_st_nxt = NORMAL;
            end
         end
         default: begin
            w_empty = (w_diff == '0);
            // this write leaves less than one word of room
            if (w_en_int && (w_fill + W_INCR) > (FIFO_SIZE - W_INCR)) begin
               w_st_nxt = FULL;
            end
         end
      endcase
   end

   // read domain FSM
   always_ff @(posedge r_clk) begin
      if (reset) begin
         r_st <= INIT;
      end else begin
         r_st <= r_st_nxt;
      end
   end

   always_comb begin
      r_st_nxt = r_st;
      r_empty  = 1'b0;
      r_full   = 1'b0;
      r_level  = r_fill;
      case (r_st)
         INIT: begin
            r_empty  = 1'b1;
            r_full   = 1'b1;
            r_st_nxt = EMPTY;
         end
         EMPTY: begin
            r_empty = 1'b1;
            // at least one whole read word has arrived
            if (r_fill >= R_INCR) begin
               r_st_nxt = NORMAL;
            end
         end
         default: begin
            r_full = (r_fill == FIFO_SIZE);
            // this read leaves less than one read word
            if (r_en_int && (r_fill - R_INCR) < R_INCR) begin
               r_st_nxt = EMPTY;
            end
         end
      endcase
   end

   // write pointer
   gray_counter #(
      .W (W_PTR_W)
   ) u_w_ptr (
      .clk   (w_clk),
      .reset (reset),
      .en    (w_en_int),
      .bin   (w_wptr_bin),
      .gray  (w_wptr_gray)
   );

   // read pointer
   gray_counter #(
      .W (R_PTR_W)
   ) u_r_ptr (
      .clk   (r_clk),
      .reset (reset),
      .en    (r_en_int),
      .bin   (r_rptr_bin),
      .gray  (r_rptr_gray)
   );

   // write pointer into the read domain
   gray_sync #(
      .W (W_PTR_W)
   ) u_w2r_sync (
      .clk     (r_clk),
      .reset   (reset),
      .gray_in (w_wptr_gray),
      .bin_out (r_wptr_bin)
   );

   // read pointer into the write domain
   gray_sync #(
      .W (R_PTR_W)
   ) u_r2w_sync (
      .clk     (w_clk),
      .reset   (reset),
      .gray_in (r_rptr_gray),
      .bin_out (w_rptr_bin)
   );

   ram_t2p_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) u_ram (
      .w_clk  (w_clk),
      .w_en   (w_en_int),
      .w_addr (w_wptr_bin),
      .w_data (w_data),
      .r_clk  (r_clk),
      .r_en   (r_en_int),
      .r_addr (r_rptr_bin),
      .r_data (r_data)
   );

   // accepted strobes keep the true level between 0 and the capacity
   a_w_level_bound: assert property (@(posedge w_clk) disable iff (reset)
      w_en_int |-> (w_fill + W_INCR) <= FIFO_SIZE);

   a_r_level_bound: assert property (@(posedge r_clk) disable iff (reset)
      r_en_int |-> r_fill >= R_INCR);

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
   parameter int PERIOD = 40,
   parameter int PHASE  = 0
) (
   output logic clk
);

   // low for PHASE ns, then free running at a 50 percent duty cycle
   initial begin
      clk = 1'b0;
      #(PHASE);
      forever begin
         #(PERIOD / 2);
         clk = 1'b1;
         #(PERIOD - PERIOD / 2);
         clk = 1'b0;
      end
   end

endmodule

// ==== fifo_async_tb.sv ====
`timescale 1ns/100ps

module fifo_async_tb;

   localparam int W_DATA_W      = 32;
   localparam int R_DATA_W      = 8;
   localparam int ADDR_W        = 6;
   localparam int CLK_PERIOD    = 40;
   localparam int R_PHASE       = 13;
   localparam int DEPTH_BYTES   = 64;
   localparam int WORD_BYTES    = 4;
   localparam int DEPTH_WORDS   = DEPTH_BYTES / WORD_BYTES;
   localparam int STREAM_CYCLES = 400;
   localparam int DRAIN_LIMIT   = 200;
   localparam logic [31:0] SEED = 32'h8f3b37aa;

   // cycle budget of each test
   localparam int BUDGET_RESET  = 30;
   localparam int BUDGET_SINGLE = 40;
   localparam int BUDGET_FILL   = 40;
   localparam int BUDGET_DRAIN  = 100;
   localparam int BUDGET_STREAM = STREAM_CYCLES + DRAIN_LIMIT + 20;
   localparam int TIMEOUT_NS    = 2 * CLK_PERIOD *
      (BUDGET_RESET + BUDGET_SINGLE + BUDGET_FILL + BUDGET_DRAIN + BUDGET_STREAM);

   logic                reset;
   logic                w_clk;
   logic                w_en;
   logic [W_DATA_W-1:0] w_data;
   logic                w_empty;
   logic                w_full;
   logic [ADDR_W:0]     w_level;
   logic                r_clk;
   logic                r_en;
   logic [R_DATA_W-1:0] r_data;
   logic                r_empty;
   logic                r_full;
   logic [ADDR_W:0]     r_level;

   // bytes in the order the read port must return them
   logic [7:0]  sb [$];
   logic        read_pending;
   logic [31:0] read_expect;
   logic [31:0] rand_state;
   int          error_count = 0;
   int          check_count = 0;

   tb_clock #(.PERIOD(CLK_PERIOD), .PHASE(0)) u_w_clock (.clk(w_clk));
   tb_clock #(.PERIOD(CLK_PERIOD), .PHASE(R_PHASE)) u_r_clock (.clk(r_clk));

   fifo_async #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) UUT (
      .reset   (reset),
      .w_clk   (w_clk),
      .w_en    (w_en),
      .w_data  (w_data),
      .w_empty (w_empty),
      .w_full  (w_full),
      .w_level (w_level),
      .r_clk   (r_clk),
      .r_en    (r_en),
      .r_data  (r_data),
      .r_empty (r_empty),
      .r_full  (r_full),
      .r_level (r_level)
   );

   function automatic logic [31:0] lcg(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      end
   endtask

   task automatic report_failure(input string msg);
      error_count++;
      $display("Failure at %0t ns: %s", $time, msg);
   endtask

   task automatic wait_w_cycles(input int n);
      repeat (n) @(posedge w_clk);
      #2;
   endtask

   // one w_clk cycle, a write counts only when w_full is low at the edge
   task automatic write_cycle(input logic en, input logic [31:0] data, output logic accepted);
      @(posedge w_clk);
      #2;
      accepted = en && !w_full;
      w_en = en;
      w_data = data;
      if (accepted) begin
         for (int i = 0; i < WORD_BYTES; i++) begin
            sb.push_back(data[i*8 +: 8]);
         end
      end
   endtask

   // one r_clk cycle, also checks the byte of the previous accepted read
   task automatic read_cycle(input logic en, output logic accepted);
      @(posedge r_clk);
      #2;
      if (read_pending) begin
         check_value("r_data", read_expect, 32'(r_data));
      end
      accepted = en && !r_empty;
      r_en = en;
      read_pending = accepted;
      if (accepted) begin
         if (sb.size() == 0) begin
            report_failure("read accepted while the scoreboard holds no data");
            read_pending = 1'b0;
         end else begin
            read_expect = 32'(sb.pop_front());
         end
      end
   endtask

   task automatic test_reset();
      $display("test_reset");
      wait_w_cycles(3);
      check_value("w_empty", 1, 32'(w_empty));
      check_value("r_empty", 1, 32'(r_empty));
      check_value("w_full", 0, 32'(w_full));
      check_value("r_full", 0, 32'(r_full));
      check_value("w_level", 0, 32'(w_level));
      check_value("r_level", 0, 32'(r_level));
   endtask

   task automatic test_single_word();
      logic acc;
      bit   seen;
      $display("test_single_word");
      write_cycle(1'b1, 32'h4d3c2b1a, acc);
      check_value("write accepted", 1, 32'(acc));
      write_cycle(1'b0, '0, acc);
      seen = 1'b0;
      for (int i = 0; i < 10 && !seen; i++) begin
         read_cycle(1'b0, acc);
         seen = !r_empty;
      end
      if (!seen) begin
         report_failure("r_empty did not fall within 10 r_clk cycles after a write");
      end
      repeat (WORD_BYTES) begin
         read_cycle(1'b1, acc);
         check_value("read accepted", 1, 32'(acc));
      end
      read_cycle(1'b0, acc);
      check_value("r_empty", 1, 32'(r_empty));
   endtask

   task automatic test_fill();
      logic acc;
      $display("test_fill");
      // let the read pointer reach the write domain
      wait_w_cycles(4);
      for (int i = 0; i < DEPTH_WORDS; i++) begin
         rand_state = lcg(rand_state);
         write_cycle(1'b1, rand_state, acc);
         check_value("write accepted", 1, 32'(acc));
      end
      write_cycle(1'b0, '0, acc);
      check_value("w_full", 1, 32'(w_full));
      wait_w_cycles(3);
      check_value("w_level", DEPTH_BYTES, 32'(w_level));
      check_value("r_level", DEPTH_BYTES, 32'(r_level));
      check_value("r_full", 1, 32'(r_full));
      // new data offered while full must be dropped
      repeat (2) begin
         rand_state = lcg(rand_state);
         write_cycle(1'b1, rand_state, acc);
         check_value("write accepted while full", 0, 32'(acc));
      end
      write_cycle(1'b0, '0, acc);
      check_value("w_full", 1, 32'(w_full));
      check_value("w_level", DEPTH_BYTES, 32'(w_level));
   endtask

   task automatic test_drain();
      logic acc;
      $display("test_drain");
      for (int i = 0; i < DEPTH_BYTES; i++) begin
         read_cycle(1'b1, acc);
         check_value("read accepted", 1, 32'(acc));
      end
      read_cycle(1'b0, acc);
      check_value("r_empty", 1, 32'(r_empty));
      // a read on an empty FIFO changes nothing
      read_cycle(1'b1, acc);
      read_cycle(1'b0, acc);
      check_value("r_level", 0, 32'(r_level));
      check_value("r_empty", 1, 32'(r_empty));
      check_value("scoreboard size", 0, 32'(sb.size()));
      wait_w_cycles(4);
      check_value("w_empty", 1, 32'(w_empty));
      check_value("w_full", 0, 32'(w_full));
      check_value("w_level", 0, 32'(w_level));
   endtask

   task automatic test_stream();
      logic        w_acc;
      logic        r_acc;
      logic        w_pick;
      logic        r_pick;
      logic [31:0] w_word;
      int          guard;
      $display("test_stream");
      fork
         begin
            repeat (STREAM_CYCLES) begin
               rand_state = lcg(rand_state);
               w_pick = rand_state[16];
               rand_state = lcg(rand_state);
               w_word = rand_state;
               write_cycle(w_pick, w_word, w_acc);
            end
            write_cycle(1'b0, '0, w_acc);
         end
         begin
            repeat (STREAM_CYCLES) begin
               rand_state = lcg(rand_state);
               // reads come more often, but each write brings four bytes
               r_pick = (rand_state[17:16] != 2'b00);
               read_cycle(r_pick, r_acc);
            end
         end
      join
      guard = 0;
      while (sb.size() > 0 && guard < DRAIN_LIMIT) begin
         read_cycle(1'b1, r_acc);
         guard++;
      end
      read_cycle(1'b0, r_acc);
      if (sb.size() != 0) begin
         report_failure("final drain did not empty the FIFO");
      end
      wait_w_cycles(6);
      check_value("scoreboard size", 0, 32'(sb.size()));
      check_value("w_level", 0, 32'(w_level));
      check_value("r_level", 0, 32'(r_level));
      check_value("w_empty", 1, 32'(w_empty));
      check_value("r_empty", 1, 32'(r_empty));
   endtask

   initial begin
      reset = 1'b1;
      w_en = 1'b0;
      w_data = '0;
      r_en = 1'b0;
      read_pending = 1'b0;
      read_expect = '0;
      rand_state = SEED;
      // both domains see at least 10 edges in reset
      repeat (10) @(posedge r_clk);
      @(posedge w_clk);
      #2;
      reset = 1'b0;
      test_reset();
      test_single_word();
      test_fill();
      test_drain();
      test_stream();
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(TIMEOUT_NS);
      error_count++;
      $display("Simulation timed out after %0d ns", TIMEOUT_NS);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      $display("Test failures found");
      $finish;
   end

endmodule

// ==== verilog.f ====
fifo_pkg.sv
gray_counter.sv
gray_sync.sv
ram_t2p_asym.sv
fifo_async.sv
tb_clock.sv
fifo_async_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fifo_async testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module fifo_async_tb -f verilog.f -o fifo_async_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/fifo_async_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test failures found" sim.log; then
   echo "simulation reported failures"
   exit 1
fi

echo "simulation passed"
exit 0
